// File: corr_consts.svh
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// ====================
// array sizes.
`define CORR_NUM_INPUTS 4
`define CORR_DELAY_SIZE 8
`define CORR_LAG_AUTO 2
`define CORR_RESOLUTION 16

`define CORR_NUM_BASELINES (`CORR_NUM_INPUTS * (`CORR_NUM_INPUTS - 1) / 2)
`define CORR_NUM_COUNTERS (`CORR_NUM_INPUTS * `CORR_LAG_AUTO + `CORR_NUM_BASELINES)
`define CORR_FRAME_WORDS (2 + `CORR_NUM_COUNTERS)
`define CORR_MAX_AUTO_LAG (`CORR_DELAY_SIZE - `CORR_LAG_AUTO) // highest legal auto_lag.

// ====================
// register map, word addresses.
`define CORR_ADR_CTRL 8'd0
`define CORR_ADR_STATUS 8'd1
`define CORR_ADR_LENGTH 8'd2
`define CORR_ADR_CHAN 8'd4
`define CORR_ADR_FRAME 8'd16

`endif

// File: corr_pkg.sv
package corr_pkg;

	// wishbone classic, master to slave.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [7:0] adr; // word address.
		logic [31:0] dat;
	} wb_req_t;

	// slave to master.
	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// per input setup, lives in bits 7:0 of a channel register.
	typedef struct packed {
		logic enable;
		logic invert;
		logic [2:0] cross_lag;
		logic [2:0] auto_lag;
	} chan_cfg_t;

	typedef enum logic [1:0] {
		CTRL_NOP = 2'd0,
		CTRL_START = 2'd1,
		CTRL_CLEAR_SEQ = 2'd2
	} ctrl_op_e;

	typedef enum logic [1:0] {
		FB_IDLE,
		FB_INTEGRATE,
		FB_LATCH
	} frame_state_e;

endpackage

// File: delay_line.sv
`timescale 1ns/1ns
`include "corr_consts.svh"

module delay_line (
	input  logic intclk,
	input  logic reset,
	input  logic clear,
	input  logic [`CORR_NUM_INPUTS-1:0] samples,
	input  logic sample_valid,
	output logic [`CORR_NUM_INPUTS-1:0][`CORR_DELAY_SIZE-1:0] taps
);
	// bit k-1 holds the valid sample from k valid cycles ago.
	logic [`CORR_NUM_INPUTS-1:0][`CORR_DELAY_SIZE-2:0] hist;

	always_ff @(posedge intclk) begin
		if (reset || clear) begin
			hist <= '0;
		end else if (sample_valid) begin
			for (int a = 0; a < `CORR_NUM_INPUTS; a++) begin
				hist[a] <= {hist[a][`CORR_DELAY_SIZE-3:0], samples[a]};
			end
		end
	end

	// tap 0 is the live sample.
	always_comb begin
		for (int a = 0; a < `CORR_NUM_INPUTS; a++) begin
			taps[a] = {hist[a], samples[a]};
		end
	end

endmodule

// File: corr_counter.sv
`timescale 1ns/1ns
`include "corr_consts.svh"

module corr_counter (
	input  logic intclk,
	input  logic reset,
	input  logic clear,
	input  logic count_en,
	input  logic [`CORR_DELAY_SIZE-1:0] taps_x,
	input  logic [`CORR_DELAY_SIZE-1:0] taps_y,
	input  logic [2:0] lag_x,
	input  logic [2:0] lag_y,
	input  logic invert_x,
	input  logic invert_y,
	input  logic pair_enable,
	output logic [`CORR_RESOLUTION-1:0] count,
	output logic saturated
);
	logic bit_x;
	logic bit_y;
	logic agree;

	always_comb begin
		bit_x = taps_x[lag_x] ^ invert_x;
		bit_y = taps_y[lag_y] ^ invert_y;
		agree = ~(bit_x ^ bit_y); // 1-bit product.
	end

	always_ff @(posedge intclk) begin
		if (reset || clear) begin
			count <= '0;
			saturated <= 1'b0;
		end else if (count_en && pair_enable && agree) begin
			// hold at full scale, flag the lost count.
			if (count == '1) begin
				saturated <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// File: frame_builder.sv
`timescale 1ns/1ns
`include "corr_consts.svh"

module frame_builder (
	input  logic intclk,
	input  logic reset,
	input  logic start_pulse,
	input  logic clear_seq,
	input  logic sample_valid,
	input  logic [15:0] length,
	input  logic [`CORR_NUM_COUNTERS-1:0][`CORR_RESOLUTION-1:0] counts,
	input  logic [`CORR_NUM_COUNTERS-1:0] counter_sat,
	input  logic [3:0] frame_index,
	output logic clear,
	output logic count_en,
	output logic busy,
	output logic frame_ready,
	output logic saturated,
	output logic [31:0] frame_word
);
	corr_pkg::frame_state_e state;
	logic [15:0] len_q;
	logic [15:0] n_valid;
	logic [31:0] seq;
	logic [31:0] frame_seq;
	logic [15:0] frame_len;
	logic [`CORR_NUM_COUNTERS-1:0][`CORR_RESOLUTION-1:0] frame_counts;

	assign clear = start_pulse; // counters and delay line restart together.
	assign busy = (state != corr_pkg::FB_IDLE);
	assign count_en = (state == corr_pkg::FB_INTEGRATE) && sample_valid;

	// ====================
	// integration fsm.
	always_ff @(posedge intclk) begin
		if (reset) begin
			state <= corr_pkg::FB_IDLE;
			n_valid <= '0;
			seq <= '0;
			frame_ready <= 1'b0;
		end else begin
			case (state)
				corr_pkg::FB_IDLE: begin
					if (start_pulse) begin
						state <= corr_pkg::FB_INTEGRATE;
						n_valid <= '0;
						frame_ready <= 1'b0;
					end
				end
				corr_pkg::FB_INTEGRATE: begin
					if (sample_valid) begin
						n_valid <= n_valid + 16'd1;
						if (n_valid == len_q - 16'd1) state <= corr_pkg::FB_LATCH;
					end
				end
				corr_pkg::FB_LATCH: begin
					state <= corr_pkg::FB_IDLE;
					frame_ready <= 1'b1;
					seq <= seq + 32'd1;
				end
				default: state <= corr_pkg::FB_IDLE;
			endcase
			if (clear_seq) seq <= '0;
		end
	end

	always_ff @(posedge intclk) begin
		if (state == corr_pkg::FB_IDLE && start_pulse) len_q <= length;
	end

	// ====================
	// frame storage, zero until the first frame.
	always_ff @(posedge intclk) begin
		if (reset) begin
			frame_seq <= '0;
			frame_len <= '0;
			frame_counts <= '0;
			saturated <= 1'b0;
		end else if (state == corr_pkg::FB_LATCH) begin
			frame_seq <= seq;
			frame_len <= len_q;
			frame_counts <= counts;
			saturated <= |counter_sat;
		end
	end

	always_comb begin
		if (frame_index == 4'd0) begin
			frame_word = frame_seq;
		end else if (frame_index == 4'd1) begin
			frame_word = {16'd0, frame_len};
		end else begin
			frame_word = {{(32 - `CORR_RESOLUTION){1'b0}}, frame_counts[frame_index - 4'd2]};
		end
	end

endmodule

// File: corr_regs.sv
`timescale 1ns/1ns
`include "corr_consts.svh"

module corr_regs (
	input  logic intclk,
	input  logic reset,
	input  corr_pkg::wb_req_t bus_req,
	output corr_pkg::wb_rsp_t bus_rsp,
	input  logic busy,
	input  logic frame_ready,
	input  logic saturated,
	input  logic [31:0] frame_word,
	output corr_pkg::chan_cfg_t [`CORR_NUM_INPUTS-1:0] cfg,
	output logic [15:0] length,
	output logic start_pulse,
	output logic clear_seq,
	output logic [3:0] frame_index
);
	logic ack;
	logic [31:0] rdat;
	logic access;
	logic is_chan;
	logic is_frame;
	logic [$clog2(`CORR_NUM_INPUTS)-1:0] chan_sel;
	logic [31:0] rd_mux;
	corr_pkg::ctrl_op_e op;

	// limit auto_lag so auto_lag+y stays inside the delay line.
	function automatic corr_pkg::chan_cfg_t clamp_cfg(input logic [7:0] raw);
		corr_pkg::chan_cfg_t c;
		c = corr_pkg::chan_cfg_t'(raw);
		if (c.auto_lag > 3'(`CORR_MAX_AUTO_LAG)) c.auto_lag = 3'(`CORR_MAX_AUTO_LAG);
		return c;
	endfunction

	// ====================
	// address decode.
	always_comb begin
		access = bus_req.cyc && bus_req.stb && !ack; // one ack per request.
		is_chan = (bus_req.adr >= `CORR_ADR_CHAN) &&
			(bus_req.adr < `CORR_ADR_CHAN + `CORR_NUM_INPUTS);
		is_frame = (bus_req.adr >= `CORR_ADR_FRAME) &&
			(bus_req.adr < `CORR_ADR_FRAME + `CORR_FRAME_WORDS);
		chan_sel = $clog2(`CORR_NUM_INPUTS)'(bus_req.adr - `CORR_ADR_CHAN);
		frame_index = 4'(bus_req.adr - `CORR_ADR_FRAME);
		op = corr_pkg::ctrl_op_e'(bus_req.dat[1:0]);
	end

	always_comb begin
		rd_mux = '0; // unmapped and control read zero.
		if (bus_req.adr == `CORR_ADR_STATUS) begin
			rd_mux = {29'd0, saturated, frame_ready, busy};
		end else if (bus_req.adr == `CORR_ADR_LENGTH) begin
			rd_mux = {16'd0, length};
		end else if (is_chan) begin
			rd_mux = {24'd0, cfg[chan_sel]};
		end else if (is_frame) begin
			rd_mux = frame_word;
		end
	end

	// ====================
	// writes land on the edge that raises ack.
	always_ff @(posedge intclk) begin
		if (reset) begin
			ack <= 1'b0;
			start_pulse <= 1'b0;
			clear_seq <= 1'b0;
			length <= 16'd1;
			cfg <= '0;
		end else begin
			ack <= access;
			start_pulse <= 1'b0;
			clear_seq <= 1'b0;
			if (access && bus_req.we) begin
				if (bus_req.adr == `CORR_ADR_CTRL) begin
					if (op == corr_pkg::CTRL_START) start_pulse <= !busy;
					if (op == corr_pkg::CTRL_CLEAR_SEQ) clear_seq <= 1'b1;
				end else if (bus_req.adr == `CORR_ADR_LENGTH) begin
					length <= (bus_req.dat[15:0] == 16'd0) ? 16'd1 : bus_req.dat[15:0];
				end else if (is_chan) begin
					cfg[chan_sel] <= clamp_cfg(bus_req.dat[7:0]);
				end
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (access) rdat <= rd_mux;
	end

	always_comb begin
		bus_rsp.ack = ack;
		bus_rsp.dat = rdat;
	end

endmodule

// File: correlator_top.sv
`timescale 1ns/1ns
`include "corr_consts.svh"

module correlator_top (
	input  logic intclk,
	input  logic reset,
	input  logic [`CORR_NUM_INPUTS-1:0] samples,
	input  logic sample_valid,
	input  corr_pkg::wb_req_t bus_req,
	output corr_pkg::wb_rsp_t bus_rsp,
	output logic frame_irq
);
	logic [`CORR_NUM_INPUTS-1:0][`CORR_DELAY_SIZE-1:0] taps;
	corr_pkg::chan_cfg_t [`CORR_NUM_INPUTS-1:0] cfg;
	logic [15:0] length;
	logic start_pulse;
	logic clear_seq;
	logic clear;
	logic count_en;
	logic busy;
	logic saturated;
	logic [3:0] frame_index;
	logic [31:0] frame_word;
	logic [`CORR_NUM_COUNTERS-1:0][`CORR_RESOLUTION-1:0] counts;
	logic [`CORR_NUM_COUNTERS-1:0] counter_sat;

	delay_line u_delay (
		.intclk(intclk), .reset(reset), .clear(clear),
		.samples(samples), .sample_valid(sample_valid), .taps(taps)
	);

	// ====================
	// auto counters, input-major.
	for (genvar a = 0; a < `CORR_NUM_INPUTS; a++) begin : g_auto
		for (genvar y = 0; y < `CORR_LAG_AUTO; y++) begin : g_lag
			corr_counter u_cnt (
				.intclk(intclk), .reset(reset), .clear(clear), .count_en(count_en),
				.taps_x(taps[a]), .taps_y(taps[a]),
				.lag_x(3'd0), .lag_y(cfg[a].auto_lag + 3'(y)),
				.invert_x(cfg[a].invert), .invert_y(cfg[a].invert),
				.pair_enable(cfg[a].enable),
				.count(counts[a*`CORR_LAG_AUTO + y]),
				.saturated(counter_sat[a*`CORR_LAG_AUTO + y])
			);
		end
	end

	// ====================
	// cross counters, one per baseline a<b.
	for (genvar a = 0; a < `CORR_NUM_INPUTS - 1; a++) begin : g_cross_a
		for (genvar b = a + 1; b < `CORR_NUM_INPUTS; b++) begin : g_cross_b
			localparam int idx = `CORR_NUM_INPUTS * `CORR_LAG_AUTO +
				a * (2 * `CORR_NUM_INPUTS - a - 1) / 2 + (b - a - 1);
			corr_counter u_cnt (
				.intclk(intclk), .reset(reset), .clear(clear), .count_en(count_en),
				.taps_x(taps[a]), .taps_y(taps[b]),
				.lag_x(cfg[a].cross_lag), .lag_y(cfg[b].cross_lag),
				.invert_x(cfg[a].invert), .invert_y(cfg[b].invert),
				.pair_enable(cfg[a].enable & cfg[b].enable),
				.count(counts[idx]), .saturated(counter_sat[idx])
			);
		end
	end

	frame_builder u_frame (
		.intclk(intclk), .reset(reset), .start_pulse(start_pulse), .clear_seq(clear_seq),
		.sample_valid(sample_valid), .length(length), .counts(counts),
		.counter_sat(counter_sat), .frame_index(frame_index), .clear(clear),
		.count_en(count_en), .busy(busy), .frame_ready(frame_irq),
		.saturated(saturated), .frame_word(frame_word)
	);

	corr_regs u_regs (
		.intclk(intclk), .reset(reset), .bus_req(bus_req), .bus_rsp(bus_rsp),
		.busy(busy), .frame_ready(frame_irq), .saturated(saturated),
		.frame_word(frame_word), .cfg(cfg), .length(length),
		.start_pulse(start_pulse), .clear_seq(clear_seq), .frame_index(frame_index)
	);

endmodule

// File: tb_correlator.sv
`timescale 1ns/1ns
`include "corr_consts.svh"

module tb_correlator;
	localparam int total_samples = 200 + 100 + 3 * 30 + 1 + 65535;

	logic intclk;
	logic reset;
	logic [`CORR_NUM_INPUTS-1:0] samples;
	logic sample_valid;
	corr_pkg::wb_req_t bus_req;
	corr_pkg::wb_rsp_t bus_rsp;
	logic frame_irq;
	int errors;
	int checks;
	logic [31:0] rng;
	logic [31:0] got;
	logic [`CORR_NUM_INPUTS-1:0] hist[$]; // valid samples since start.
	logic [7:0] cfg_tb [`CORR_NUM_INPUTS];
	logic [31:0] exp_words [`CORR_FRAME_WORDS];
	logic exp_sat;

	correlator_top UUT (
		.intclk(intclk), .reset(reset), .samples(samples), .sample_valid(sample_valid),
		.bus_req(bus_req), .bus_rsp(bus_rsp), .frame_irq(frame_irq)
	);

	always #2 intclk = ~intclk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// tap k of input a at valid sample i. taps before start read zero.
	function automatic logic tap_bit(input int i, input int a, input int k);
		if (i - k < 0) return 1'b0;
		return hist[i - k][a];
	endfunction

	function automatic void ref_frame(input logic [31:0] seq, input logic [15:0] len);
		int cnt [`CORR_NUM_COUNTERS];
		int in_x [`CORR_NUM_COUNTERS];
		int in_y [`CORR_NUM_COUNTERS];
		int lx [`CORR_NUM_COUNTERS];
		int ly [`CORR_NUM_COUNTERS];
		int idx;
		int alag;
		logic bx;
		logic by;
		idx = 0;
		for (int a = 0; a < `CORR_NUM_INPUTS; a++) begin
			alag = (cfg_tb[a][2:0] > `CORR_MAX_AUTO_LAG) ? `CORR_MAX_AUTO_LAG : cfg_tb[a][2:0];
			for (int y = 0; y < `CORR_LAG_AUTO; y++) begin
				in_x[idx] = a;
				in_y[idx] = a;
				lx[idx] = 0;
				ly[idx] = alag + y;
				idx++;
			end
		end
		for (int a = 0; a < `CORR_NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < `CORR_NUM_INPUTS; b++) begin
				in_x[idx] = a;
				in_y[idx] = b;
				lx[idx] = cfg_tb[a][5:3];
				ly[idx] = cfg_tb[b][5:3];
				idx++;
			end
		end
		exp_sat = 1'b0;
		for (int c = 0; c < `CORR_NUM_COUNTERS; c++) cnt[c] = 0;
		for (int i = 0; i < len; i++) begin
			for (int c = 0; c < `CORR_NUM_COUNTERS; c++) begin
				bx = tap_bit(i, in_x[c], lx[c]) ^ cfg_tb[in_x[c]][6];
				by = tap_bit(i, in_y[c], ly[c]) ^ cfg_tb[in_y[c]][6];
				if (cfg_tb[in_x[c]][7] && cfg_tb[in_y[c]][7] && bx == by) begin
					if (cnt[c] == (1 << `CORR_RESOLUTION) - 1) exp_sat = 1'b1;
					else cnt[c]++;
				end
			end
		end
		exp_words[0] = seq;
		exp_words[1] = {16'd0, len};
		for (int c = 0; c < `CORR_NUM_COUNTERS; c++) exp_words[2 + c] = cnt[c];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// ====================
	// wishbone master.
	task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
		@(negedge intclk);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = 1'b1;
		bus_req.adr = adr;
		bus_req.dat = dat;
		do @(negedge intclk); while (!bus_rsp.ack);
		bus_req = '0;
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
		@(negedge intclk);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = 1'b0;
		bus_req.adr = adr;
		do @(negedge intclk); while (!bus_rsp.ack);
		dat = bus_rsp.dat; // held for the ack cycle.
		bus_req = '0;
	endtask

	task automatic set_chan(input int a, input logic [7:0] val);
		cfg_tb[a] = val;
		wb_write(`CORR_ADR_CHAN + 8'(a), {24'd0, val});
	endtask

	task automatic drive_samples(input int n, input bit constant);
		int sent;
		sent = 0;
		while (sent < n) begin
			@(negedge intclk);
			rng = xorshift(rng);
			sample_valid = constant || (rng[9:8] != 2'b00); // about one gap in four.
			samples = constant ? '1 : rng[3:0];
			if (sample_valid) begin
				hist.push_back(samples);
				sent++;
			end
		end
		@(negedge intclk);
		sample_valid = 1'b0;
	endtask

	task automatic run_frame(input string name, input logic [15:0] len, input logic [31:0] seq,
			input bit constant, input bit poke);
		logic [15:0] eff;
		eff = (len == 16'd0) ? 16'd1 : len;
		hist.delete();
		wb_write(`CORR_ADR_LENGTH, {16'd0, len});
		wb_write(`CORR_ADR_CTRL, 32'(corr_pkg::CTRL_START));
		fork
			drive_samples(eff, constant);
			if (poke) begin
				repeat (3) @(negedge intclk);
				wb_write(`CORR_ADR_CTRL, 32'(corr_pkg::CTRL_START)); // dropped while busy.
				wb_read(`CORR_ADR_STATUS, got);
				check_value({name, " busy status"}, {29'd0, exp_sat, 2'b01}, got);
			end
		join
		while (!frame_irq) @(negedge intclk);
		ref_frame(seq, eff);
		for (int w = 0; w < `CORR_FRAME_WORDS; w++) begin
			wb_read(`CORR_ADR_FRAME + 8'(w), got);
			check_value($sformatf("%s word %0d", name, w), exp_words[w], got);
		end
		wb_read(`CORR_ADR_STATUS, got);
		check_value({name, " status"}, {29'd0, exp_sat, 2'b10}, got);
	endtask

	initial begin
		#(total_samples * 200 + 2000);
		$display("timeout, the frame never completed within the time limit");
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ====================
	// test sequence.
	initial begin
		intclk = 1'b0;
		reset = 1'b1;
		samples = '0;
		sample_valid = 1'b0;
		bus_req = '0;
		errors = 0;
		checks = 0;
		rng = 32'd17562;
		for (int a = 0; a < `CORR_NUM_INPUTS; a++) cfg_tb[a] = 8'h00;
		repeat (2) @(negedge intclk);
		reset = 1'b0;

		wb_read(`CORR_ADR_STATUS, got);
		check_value("reset status", 32'd0, got);
		check_value("reset irq", 32'd0, {31'd0, frame_irq});
		for (int w = 0; w < `CORR_FRAME_WORDS; w++) begin
			wb_read(`CORR_ADR_FRAME + 8'(w), got);
			check_value($sformatf("reset word %0d", w), 32'd0, got);
		end

		set_chan(0, 8'h89);
		set_chan(1, 8'hC2);
		set_chan(2, 8'h98);
		set_chan(3, 8'hFE);
		run_frame("random", 16'd200, 32'd0, 1'b0, 1'b0);

		set_chan(2, 8'h18); // input 2 off.
		set_chan(3, 8'hFF);
		wb_read(`CORR_ADR_CHAN + 8'd3, got);
		check_value("chan 3 clamp", 32'h0000_00FE, got);
		run_frame("disable", 16'd100, 32'd1, 1'b0, 1'b0);

		wb_write(`CORR_ADR_CTRL, 32'(corr_pkg::CTRL_CLEAR_SEQ));
		run_frame("seq 0", 16'd30, 32'd0, 1'b0, 1'b0);
		run_frame("seq 1", 16'd30, 32'd1, 1'b0, 1'b1);
		run_frame("seq 2", 16'd30, 32'd2, 1'b0, 1'b0);
		wb_write(`CORR_ADR_CTRL, 32'(corr_pkg::CTRL_CLEAR_SEQ));
		run_frame("length 0", 16'd0, 32'd0, 1'b0, 1'b0);
		wb_read(`CORR_ADR_LENGTH, got);
		check_value("length readback", 32'd1, got);

		for (int a = 0; a < `CORR_NUM_INPUTS; a++) set_chan(a, 8'h80);
		run_frame("full scale", 16'd65535, 32'd1, 1'b1, 1'b0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+.
corr_pkg.sv
delay_line.sv
corr_counter.sv
frame_builder.sv
corr_regs.sv
correlator_top.sv
tb_correlator.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_correlator \
	-o tb_correlator > build.log 2>&1 &&
	./obj_dir/tb_correlator > sim.log 2>&1 ||
	echo "build or simulation returned an error, see build.log and sim.log"
grep -q "Simulation finished: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
